// ==== compile.f ====
source/i2c_pkg.sv
source/eeprom_pkg.sv
source/i2c_phase_timer.sv
source/i2c_phy.sv
source/eeprom_seq.sv
source/eeprom_ctrl_top.sv
sim/eeprom_model.sv
sim/tb_eeprom_ctrl.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_eeprom_ctrl
RTL_TOP    := eeprom_ctrl_top
FILELIST   := compile.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/tb_eeprom_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;
  import eeprom_pkg::*;
  import i2c_pkg::*;

  localparam int ACK_TIMEOUT = 8 * 36 * QUARTER_CYCLES; // well over one read
  localparam int N_RANDOM    = 60;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        wr;
  logic        rd;
  addr_t       addr;
  byte_t       wdata;
  logic        ack;
  logic        busy;
  byte_t       rdata;
  logic        err;
  logic        scl;
  logic        sda_oe;
  logic        sda_line;
  logic        model_pull;
  logic        force_nack;
  addr_t       model_addr;
  logic [31:0] seed = 32'h7c1827b5;
  byte_t       ref_mem [2**ADDR_W];
  int          pending = 0;

  always #50 clk = ~clk;

  assign sda_line = !(sda_oe || model_pull); // wired and of both pull-downs

  eeprom_ctrl_top i_eeprom_ctrl_top (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (wr),
    .rd     (rd),
    .addr   (addr),
    .wdata  (wdata),
    .ack    (ack),
    .busy   (busy),
    .rdata  (rdata),
    .err    (err),
    .scl    (scl),
    .sda_oe (sda_oe),
    .sda_in (sda_line)
  );

  eeprom_model i_eeprom_model (
    .clk        (clk),
    .scl        (scl),
    .sda        (sda_line),
    .force_nack (force_nack),
    .pull       (model_pull),
    .last_addr  (model_addr)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rdata(input byte_t got, input byte_t exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: rdata got %02h expected %02h", $time, got, exp));
  endtask

  task automatic check_err(input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: err got %b expected %b", $time, got, exp));
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: model address got %03h expected %03h",
                         $time, got, exp));
  endtask

  task automatic check_bus_idle(input logic scl_v, input logic oe_v);
    if (scl_v !== 1'b1)
      fail_run($sformatf("MISMATCH at %0t: scl got %b expected 1", $time, scl_v));
    if (oe_v !== 1'b0)
      fail_run($sformatf("MISMATCH at %0t: sda_oe got %b expected 0", $time, oe_v));
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > ACK_TIMEOUT)
        fail_run("timeout: the controller never pulsed ack");
    end while (!ack);
  endtask

  task automatic strobe(input logic is_wr, input addr_t a, input byte_t d);
    @(posedge clk);
    wr    <= is_wr;
    rd    <= ~is_wr;
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    wr <= 1'b0;
    rd <= 1'b0;
  endtask

  task automatic write_cell(input addr_t a, input byte_t d);
    strobe(1'b1, a, d);
    wait_ack();
    check_err(err, 1'b0);
    check_addr(model_addr, a);
    ref_mem[a] = d;
  endtask

  task automatic read_cell(input addr_t a);
    strobe(1'b0, a, 8'h00);
    wait_ack();
    check_err(err, 1'b0);
    check_addr(model_addr, a);
    check_rdata(rdata, ref_mem[a]);
  endtask

  // ack only after an accepted strobe and an idle bus while not busy
  always @(negedge clk) begin
    if (arst_n) begin
      if ((wr || rd) && !busy)
        pending = pending + 1;
      if (ack) begin
        if (pending == 0)
          fail_run("ack pulsed without an accepted wr or rd strobe");
        pending = pending - 1;
      end
      if (!busy)
        check_bus_idle(scl, sda_oe);
    end
  end

  initial begin
    addr_t       a;
    addr_t       a2;
    addr_t       last_wr;
    byte_t       d;
    logic [31:0] r;
    for (int i = 0; i < 2**ADDR_W; i++)
      ref_mem[i] = 8'hff;
    arst_n     <= 1'b0;
    wr         <= 1'b0;
    rd         <= 1'b0;
    addr       <= '0;
    wdata      <= '0;
    force_nack <= 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) @(posedge clk);

    // write then read back
    a = addr_t'(next_rand() >> 21);
    d = byte_t'(next_rand() >> 24);
    write_cell(a, d);
    read_cell(a);
    last_wr = a;

    // random mix of writes and reads over the whole range
    for (int i = 0; i < N_RANDOM; i++) begin
      r = next_rand();
      if (r[31]) begin
        write_cell(r[29:19], r[18:11]);
        last_wr = r[29:19];
      end else if (r[30]) begin
        read_cell(last_wr);
      end else begin
        read_cell(r[29:19]);
      end
    end

    // strobes while busy are dropped
    a  = addr_t'(next_rand() >> 21);
    a2 = a ^ 11'h2a5;
    d  = byte_t'(next_rand() >> 24);
    strobe(1'b1, a, d);
    repeat (20) @(posedge clk);
    strobe(1'b1, a2, ~d);
    strobe(1'b0, a2, 8'h00);
    wait_ack();
    check_err(err, 1'b0);
    check_addr(model_addr, a);
    ref_mem[a] = d;
    for (int i = 0; i < ACK_TIMEOUT; i++) begin
      @(negedge clk);
      if (busy)
        fail_run("a strobe raised while busy started a second transfer");
    end
    read_cell(a);
    read_cell(a2);

    // forced slave nack leaves the array unchanged
    a = addr_t'(next_rand() >> 21);
    d = ~ref_mem[a];
    @(posedge clk);
    force_nack <= 1'b1;
    strobe(1'b1, a, d);
    wait_ack();
    check_err(err, 1'b1);
    @(posedge clk);
    force_nack <= 1'b0;
    read_cell(a);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/eeprom_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
  input  wire logic         clk,
  input  wire logic         scl,
  input  wire logic         sda,
  input  wire logic         force_nack,
  output logic              pull,
  output eeprom_pkg::addr_t last_addr
);
  import eeprom_pkg::*;
  import i2c_pkg::*;

  byte_t      mem [2**ADDR_W];
  logic       drive = 1'b0;
  logic       scl_d = 1'b1;
  logic       sda_d = 1'b1;
  logic       active = 1'b0;
  logic       tx = 1'b0;
  logic       rnw = 1'b0;
  logic       mnack = 1'b0;
  logic       ok = 1'b0;
  logic [2:0] blk = '0;
  byte_t      word = '0;
  byte_t      sr = '0;
  byte_t      txb = '0;
  int         bitn = 0; // scl rises seen in the current byte
  int         idx = 0;  // byte number since the last start

  assign pull = drive;

  initial begin
    for (int i = 0; i < 2**ADDR_W; i++)
      mem[i] = 8'hff; // erased
  end

  // edges found against the previous clk sample of the bus
  always @(posedge clk) begin
    if (scl && scl_d && sda_d && !sda) begin // start or repeated start
      active = 1'b1;
      tx     = 1'b0;
      bitn   = 0;
      idx    = 0;
      drive <= 1'b0;
    end else if (scl && scl_d && !sda_d && sda) begin // stop
      active = 1'b0;
      drive <= 1'b0;
    end else if (active && scl && !scl_d) begin
      if (tx && bitn == BYTE_BITS)
        mnack = sda;
      else if (!tx && bitn < BYTE_BITS)
        sr = {sr[6:0], sda};
      bitn++;
    end else if (active && !scl && scl_d) begin
      if (bitn == BYTE_BITS && !tx) begin
        ok = !force_nack;
        if (idx == 0) begin
          ok  = ok && (sr[7:4] == DEV_TYPE); // control byte
          blk = sr[3:1];
          rnw = sr[0];
          if (rnw)
            last_addr = {blk, word};
        end else if (idx == 1) begin
          word      = sr;
          last_addr = {blk, sr};
        end else if (ok) begin
          mem[{blk, word}] = sr;
        end
        active = ok; // after a nack wait for the next start
        drive <= ok;
      end else if (bitn == BYTE_BITS) begin
        drive <= 1'b0; // master's ack slot
      end else if (bitn > BYTE_BITS) begin
        bitn = 0;
        idx++;
        if (!tx && rnw) begin
          tx  = 1'b1;
          txb = mem[{blk, word}];
          drive <= ~txb[7];
        end else begin
          drive <= 1'b0;
          if (tx && mnack)
            active = 1'b0;
        end
      end else if (tx && bitn > 0) begin
        txb = {txb[6:0], 1'b0};
        drive <= ~txb[7];
      end
    end
    scl_d = scl;
    sda_d = sda;
  end

endmodule

`default_nettype wire

// ==== source/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic              wr,
  input  wire logic              rd,
  input  wire eeprom_pkg::addr_t addr,
  input  wire eeprom_pkg::byte_t wdata,
  output logic                   ack,
  output logic                   busy,
  output eeprom_pkg::byte_t      rdata,
  output logic                   err,
  output logic                   scl,
  output logic                   sda_oe,
  input  wire logic              sda_in
);
  import eeprom_pkg::*;
  import i2c_pkg::*;

  eeprom_req_t req;
  eeprom_rsp_t rsp;
  logic        req_go;
  logic        phy_go;
  phy_cmd_t    phy_cmd;
  logic        phy_done;
  phy_stat_t   phy_stat;
  logic        run;
  logic        tick;
  phase_t      phase;

  assign req_go = wr | rd;
  assign req    = '{rnw: ~wr, addr: addr, wdata: wdata}; // wr wins over rd
  assign rdata  = rsp.rdata;
  assign err    = rsp.err;

  eeprom_seq i_eeprom_seq (
    .clk      (clk),
    .arst_n   (arst_n),
    .req_go   (req_go),
    .req      (req),
    .busy     (busy),
    .ack      (ack),
    .rsp      (rsp),
    .phy_go   (phy_go),
    .phy_cmd  (phy_cmd),
    .phy_done (phy_done),
    .phy_stat (phy_stat)
  );

  i2c_phy i_i2c_phy (
    .clk      (clk),
    .arst_n   (arst_n),
    .phy_go   (phy_go),
    .phy_cmd  (phy_cmd),
    .phy_done (phy_done),
    .phy_stat (phy_stat),
    .tick     (tick),
    .phase    (phase),
    .run      (run),
    .scl      (scl),
    .sda_oe   (sda_oe),
    .sda_in   (sda_in)
  );

  i2c_phase_timer i_i2c_phase_timer (
    .clk    (clk),
    .arst_n (arst_n),
    .run    (run),
    .tick   (tick),
    .phase  (phase)
  );

endmodule

`default_nettype wire

// ==== source/eeprom_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_seq (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire logic                    req_go,
  input  wire eeprom_pkg::eeprom_req_t req,
  output logic                         busy,
  output logic                         ack,
  output eeprom_pkg::eeprom_rsp_t      rsp,
  output logic                         phy_go,
  output i2c_pkg::phy_cmd_t            phy_cmd,
  input  wire logic                    phy_done,
  input  wire i2c_pkg::phy_stat_t      phy_stat
);
  import eeprom_pkg::*;
  import i2c_pkg::*;

  typedef enum logic [10:0] {
    st_idle        = 11'b000_0000_0001,
    st_ready       = 11'b000_0000_0010,
    st_write_start = 11'b000_0000_0100,
    st_ctrl_write  = 11'b000_0000_1000,
    st_addr_write  = 11'b000_0001_0000,
    st_data_write  = 11'b000_0010_0000,
    st_read_start  = 11'b000_0100_0000,
    st_ctrl_read   = 11'b000_1000_0000,
    st_data_read   = 11'b001_0000_0000,
    st_stop        = 11'b010_0000_0000,
    st_ackn        = 11'b100_0000_0000
  } state_t;

  state_t      state;
  state_t      nxt;
  eeprom_req_t req_q;
  byte_t       rdata_q;
  logic        err_acc;
  logic        pend;
  logic        nack;
  logic        launch;

  assign nack   = phy_stat.slave_nack;
  assign busy   = (state != st_idle);
  assign ack    = (state == st_ackn);
  assign launch = (nxt != state) && !(nxt inside {st_idle, st_ready, st_ackn});

  always_comb begin
    nxt = state;
    case (state)
      st_idle:        if (req_go) nxt = st_ready;
      st_ready:       nxt = st_write_start;
      st_write_start: if (phy_done) nxt = st_ctrl_write;
      st_ctrl_write:  if (phy_done) nxt = nack ? st_stop : st_addr_write;
      st_addr_write: begin
        if (phy_done)
          nxt = nack ? st_stop : (req_q.rnw ? st_read_start : st_data_write);
      end
      st_data_write:  if (phy_done) nxt = st_stop;
      st_read_start:  if (phy_done) nxt = st_ctrl_read;
      st_ctrl_read:   if (phy_done) nxt = nack ? st_stop : st_data_read;
      st_data_read:   if (phy_done) nxt = st_stop;
      st_stop:        if (phy_done) nxt = st_ackn;
      default:        nxt = st_idle;
    endcase
  end

  // block select bits 10..8 ride in the control byte
  always_comb begin
    phy_cmd = '{op: op_stop, tx: '0};
    case (state)
      st_write_start: phy_cmd.op = op_start;
      st_ctrl_write: begin
        phy_cmd.op = op_write_byte;
        phy_cmd.tx = {DEV_TYPE, req_q.addr[ADDR_W-1:8], 1'b0};
      end
      st_addr_write: begin
        phy_cmd.op = op_write_byte;
        phy_cmd.tx = req_q.addr[7:0];
      end
      st_data_write: begin
        phy_cmd.op = op_write_byte;
        phy_cmd.tx = req_q.wdata;
      end
      st_read_start: phy_cmd.op = op_restart;
      st_ctrl_read: begin
        phy_cmd.op = op_write_byte;
        phy_cmd.tx = {DEV_TYPE, req_q.addr[ADDR_W-1:8], 1'b1};
      end
      st_data_read:   phy_cmd.op = op_read_byte_nack; // single byte read
      default:        phy_cmd.op = op_stop;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      phy_go  <= 1'b0;
      pend    <= 1'b0;
      err_acc <= 1'b0;
      rdata_q <= '0;
      rsp     <= '0;
    end else begin
      state  <= nxt;
      phy_go <= launch;
      if (phy_go)
        pend <= 1'b1;
      else if (phy_done)
        pend <= 1'b0;
      if (state == st_ready)
        err_acc <= 1'b0;
      else if (phy_done)
        err_acc <= err_acc | nack;
      if (state == st_data_read && phy_done)
        rdata_q <= phy_stat.rx;
      if (state == st_stop && phy_done)
        rsp <= '{rdata: rdata_q, err: err_acc};
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && req_go)
      req_q <= req;
  end

  a_ack_idle_phy: assert property (@(posedge clk) disable iff (!arst_n)
    ack |-> !pend);

endmodule

`default_nettype wire

// ==== source/i2c_phy.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_phy (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                phy_go,
  input  wire i2c_pkg::phy_cmd_t   phy_cmd,
  output logic                     phy_done,
  output i2c_pkg::phy_stat_t       phy_stat,
  input  wire logic                tick,
  input  wire i2c_pkg::phase_t     phase,
  output logic                     run,
  output logic                     scl,
  output logic                     sda_oe,
  input  wire logic                sda_in
);
  import i2c_pkg::*;

  phy_op_t    op_q;
  logic [7:0] shreg;
  logic [3:0] bitcnt;
  logic       nack_q;
  logic       is_cond;
  logic       last_bit;
  logic       reading;
  logic       finish;
  logic       sda_q0;

  assign is_cond  = (op_q == op_start) || (op_q == op_restart) || (op_q == op_stop);
  assign reading  = (op_q == op_read_byte_ack) || (op_q == op_read_byte_nack);
  assign last_bit = (bitcnt == 4'(BYTE_BITS)); // ack slot
  assign finish   = tick && (phase == 2'd3) && (is_cond || last_bit);

  assign phy_stat = '{rx: shreg, slave_nack: nack_q};

  // sda level set at the end of quarter 0 while scl is low
  always_comb begin
    case (op_q)
      op_start, op_restart: sda_q0 = 1'b0; // released before the start edge
      op_stop:              sda_q0 = 1'b1;
      op_write_byte:        sda_q0 = last_bit ? 1'b0 : ~shreg[7];
      op_read_byte_ack:     sda_q0 = last_bit;
      default:              sda_q0 = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_q     <= op_stop;
      run      <= 1'b0;
      scl      <= 1'b1;
      sda_oe   <= 1'b0;
      bitcnt   <= '0;
      nack_q   <= 1'b0;
      phy_done <= 1'b0;
    end else begin
      phy_done <= finish;
      if (phy_go) begin
        op_q   <= phy_cmd.op;
        run    <= 1'b1;
        bitcnt <= '0;
        nack_q <= 1'b0;
      end else if (tick) begin
        case (phase)
          2'd0: sda_oe <= sda_q0;
          2'd1: scl <= 1'b1;
          2'd2: begin
            if (is_cond)
              sda_oe <= (op_q != op_stop); // start or stop edge under high scl
            if (op_q == op_write_byte && last_bit)
              nack_q <= sda_in;
          end
          default: begin
            if (op_q != op_stop)
              scl <= 1'b0; // stop leaves the bus idle
            bitcnt <= bitcnt + 4'd1;
            if (finish)
              run <= 1'b0;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (phy_go)
      shreg <= phy_cmd.tx;
    else if (tick && op_q == op_write_byte && phase == 2'd3 && !last_bit)
      shreg <= {shreg[6:0], 1'b0};
    else if (tick && reading && phase == 2'd2 && !last_bit)
      shreg <= {shreg[6:0], sda_in}; // msb first
  end

  // data bits only move while scl is low
  a_sda_scl_high: assert property (@(posedge clk) disable iff (!arst_n)
    (scl && $past(scl) && $changed(sda_oe)) |-> is_cond);

  a_one_op: assert property (@(posedge clk) disable iff (!arst_n)
    phy_go |-> !run);

endmodule

`default_nettype wire

// ==== source/i2c_phase_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_phase_timer (
  input  wire logic       clk,
  input  wire logic       arst_n,
  input  wire logic       run,
  output logic            tick,
  output i2c_pkg::phase_t phase
);
  import i2c_pkg::*;

  logic [QCNT_W-1:0] qcnt;

  assign tick = run && (qcnt == QCNT_W'(QUARTER_CYCLES - 1)); // last cycle of quarter

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      qcnt  <= '0;
      phase <= '0;
    end else if (!run) begin
      qcnt  <= '0; // next op starts in phase 0
      phase <= '0;
    end else if (tick) begin
      qcnt  <= '0;
      phase <= phase + 2'd1;
    end else begin
      qcnt <= qcnt + 1'b1;
    end
  end

  // also catches run dropping in mid period
  a_phase_on_tick: assert property (@(posedge clk) disable iff (!arst_n)
    $changed(phase) |-> $past(tick));

endmodule

`default_nettype wire

// ==== source/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

  localparam int ADDR_W = 11;
  localparam int DATA_W = 8;

  // 24C16 device type in the upper control nibble
  localparam logic [3:0] DEV_TYPE = 4'b1010;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] byte_t;

  typedef struct packed {
    logic  rnw;
    addr_t addr;
    byte_t wdata;
  } eeprom_req_t;

  typedef struct packed {
    byte_t rdata;
    logic  err; // some byte was nacked
  } eeprom_rsp_t;

endpackage

`default_nettype wire

// ==== source/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

  // clk cycles per scl quarter
  localparam int QUARTER_CYCLES = 2;
  localparam int QCNT_W = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

  // data bits per byte without the ack slot
  localparam int BYTE_BITS = 8;

  // quarters 0 and 1 scl low, 2 and 3 scl high
  typedef logic [1:0] phase_t;

  typedef enum logic [2:0] {
    op_start,
    op_restart,
    op_stop,
    op_write_byte,
    op_read_byte_ack,
    op_read_byte_nack
  } phy_op_t;

  typedef struct packed {
    phy_op_t    op;
    logic [7:0] tx;
  } phy_cmd_t;

  typedef struct packed {
    logic [7:0] rx;
    logic       slave_nack; // ack slot high after a written byte
  } phy_stat_t;

endpackage

`default_nettype wire
